//--- compile.f
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_datapath.sv
cache/cache_control.sv
src/cache_top.sv
tests/clock_gen.sv
tests/pmem_model.sv
tests/cache_tb.sv

//--- tests/cache_tb.sv
// Assumes the DUT runs with set_bits 3 and that test addresses stay below 2 KiB, where the models do not alias.
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int set_bits     = 3;
    localparam int period_ns    = 8;
    localparam int reset_cycles = 10;
    localparam int mix_ops      = 200;
    localparam int num_ops      = 14 + mix_ops; // Directed accesses plus the random mix.
    localparam int mem_lines    = 64;
    localparam int ref_words    = mem_lines * line_words;
    localparam int ref_idx_w    = $clog2(ref_words);
    localparam int num_sets     = 1 << set_bits;
    localparam int timeout_ns   = (reset_cycles + num_ops * 20) * period_ns;

    logic            clk;
    logic            rst;
    logic            mem_read;
    logic            mem_write;
    addr_t           mem_address;
    word_t           mem_wdata;
    logic [be_w-1:0] mem_byte_enable;
    word_t           mem_rdata;
    logic            mem_resp;
    logic            stall;
    logic            pmem_read;
    logic            pmem_write;
    addr_t           pmem_address;
    line_t           pmem_rdata;
    line_t           pmem_wdata;
    logic            pmem_resp;

    word_t  ref_mem [ref_words];
    int     shadow_tag [num_sets][2];
    bit     shadow_valid [num_sets][2];
    bit     shadow_dirty [num_sets][2];
    bit     shadow_lru [num_sets];

    // Expectations of the access in flight.
    bit     pending;
    bit     exp_read;
    bit     exp_miss;
    bit     exp_wb;
    word_t  exp_rdata;
    addr_t  exp_wb_addr;
    line_t  exp_wb_line;
    bit     pmem_seen;
    int     pmem_reads;
    int     pmem_writes;
    addr_t  wb_addr_seen;
    line_t  wb_line_seen;
    int     wait_cycles;
    bit     stall_early;

    string  test_name;
    int     test_checks;
    int     test_errors;
    int     num_tests = 0;
    int     total_checks = 0;
    int     total_errors = 0;
    integer seed;

    clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    pmem_model #(
        .latency   (5),
        .line_bits ($clog2(mem_lines))
    ) u_pmem (
        .clk          (clk),
        .rst          (rst),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    cache_top #(
        .set_bits (set_bits)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .stall           (stall),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata)
    );

    function automatic addr_t make_addr(input int tag_val, input int set_idx, input int word_idx);
        return addr_t'((tag_val << (offset_w + set_bits)) | (set_idx << offset_w) | (word_idx << 2));
    endfunction

    // Expected memory contents; a write replaces only the enabled bytes.
    function automatic word_t ref_access(input addr_t addr, input bit write,
                                         input word_t wdata, input logic [be_w-1:0] be);
        int idx;
        idx = addr[2 +: ref_idx_w];
        if (write) begin
            for (int b = 0; b < be_w; b++) begin
                if (be[b])
                    ref_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return ref_mem[idx];
    endfunction

    // Predicts hit, victim and write-back, then updates tags, dirty and LRU like the cache.
    task automatic shadow_access(input addr_t addr, input bit write);
        int set_idx;
        int tag_val;
        int way;
        set_idx  = addr[offset_w +: set_bits];
        tag_val  = addr >> (offset_w + set_bits);
        way      = shadow_lru[set_idx];
        exp_miss = 1'b1;
        for (int w = 0; w < 2; w++) begin
            if (shadow_valid[set_idx][w] && shadow_tag[set_idx][w] == tag_val) begin
                exp_miss = 1'b0;
                way      = w;
            end
        end
        exp_wb      = exp_miss && shadow_valid[set_idx][way] && shadow_dirty[set_idx][way];
        exp_wb_addr = make_addr(shadow_tag[set_idx][way], set_idx, 0);
        for (int w = 0; w < line_words; w++)
            exp_wb_line[w*word_w +: word_w] = ref_mem[exp_wb_addr[2 +: ref_idx_w] + w];
        if (exp_miss) begin
            shadow_valid[set_idx][way] = 1'b1;
            shadow_tag[set_idx][way]   = tag_val;
            shadow_dirty[set_idx][way] = 1'b0;
        end
        shadow_dirty[set_idx][way] = shadow_dirty[set_idx][way] || write;
        shadow_lru[set_idx]        = (way == 0); // Points at the way not just used.
    endtask

    task automatic expect_equal(input string what, input line_t exp, input line_t act);
        test_checks++;
        assert (exp === act)
        else begin
            test_errors++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // Holds one request until mem_resp and then drops it.
    task automatic run_access(input bit write, input addr_t addr, input word_t wdata,
                              input logic [be_w-1:0] be);
        @(posedge clk);
        shadow_access(addr, write);
        exp_read    = !write;
        exp_rdata   = ref_access(addr, write, wdata, be);
        pmem_seen   = 1'b0;
        pmem_reads  = 0;
        pmem_writes = 0;
        wait_cycles = 0;
        stall_early = 1'b0;
        pending     = 1'b1;
        mem_read        <= !write;
        mem_write       <= write;
        mem_address     <= addr;
        mem_wdata       <= wdata;
        mem_byte_enable <= be;
        do
            @(negedge clk);
        while (!mem_resp);
        @(posedge clk);
        pending = 1'b0;
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
    endtask

    // Memory traffic is counted and each response is checked at the falling edge.
    always @(negedge clk) begin
        if (pending) begin
            wait_cycles++;
            pmem_seen = pmem_seen || pmem_read || pmem_write;
            if (pmem_resp && pmem_read)
                pmem_reads++;
            if (pmem_resp && pmem_write) begin
                pmem_writes++;
                wb_addr_seen = pmem_address;
                wb_line_seen = pmem_wdata;
            end
            if (!mem_resp && !stall)
                stall_early = 1'b1; // The processor must stay stalled until it is answered.
            if (mem_resp) begin
                if (exp_read)
                    expect_equal("read data", exp_rdata, mem_rdata);
                expect_equal("memory reads", exp_miss, pmem_reads);
                expect_equal("memory writes", exp_wb, pmem_writes);
                expect_equal("stall", 1'b0, stall);
                if (exp_wb) begin
                    expect_equal("write-back address", exp_wb_addr, wb_addr_seen);
                    expect_equal("write-back line", exp_wb_line, wb_line_seen);
                end
                test_checks++;
                assert (!stall_early)
                else begin
                    test_errors++;
                    $display("In %s stall was low while the access was still waiting", test_name);
                end
                if (!exp_miss) begin
                    expect_equal("hit latency", 1, wait_cycles); // A hit answers in its first cycle.
                    test_checks++;
                    assert (!pmem_seen)
                    else begin
                        test_errors++;
                        $display("In %s the cache raised a memory request on a hit", test_name);
                    end
                end
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        num_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: %0d accesses did not complete within %0d ns", num_ops, timeout_ns);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        word_t           data;
        logic [be_w-1:0] be;
        int              tag_val;
        int              set_idx;
        int              word_idx;
        seed            = 32'ha614_5a64;
        pending         = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        @(negedge clk); // The memory model has filled its lines by now.
        for (int i = 0; i < ref_words; i++)
            ref_mem[i] = u_pmem.lines[i / line_words][(i % line_words)*word_w +: word_w];
        wait (!rst);

        start_test("read_miss");
        run_access(1'b0, make_addr(0, 1, 3), '0, '0);
        end_test();

        start_test("read_hit");
        run_access(1'b0, make_addr(0, 1, 5), '0, '0);
        end_test();

        start_test("write_hit");
        data = $random(seed);
        be   = $random(seed);
        run_access(1'b1, make_addr(0, 1, 5), data, be);
        run_access(1'b0, make_addr(0, 1, 5), '0, '0);
        end_test();

        // Tag 1 is written, then pushed out of set 2 by tags 2 and 3.
        start_test("dirty_eviction");
        run_access(1'b1, make_addr(1, 2, 2), 32'h5a5a_0f0f, 4'b1011);
        run_access(1'b0, make_addr(2, 2, 0), '0, '0);
        run_access(1'b0, make_addr(3, 2, 0), '0, '0);
        run_access(1'b0, make_addr(1, 2, 2), '0, '0);
        end_test();

        start_test("lru_replacement");
        run_access(1'b0, make_addr(0, 4, 1), '0, '0);
        run_access(1'b0, make_addr(1, 4, 1), '0, '0);
        run_access(1'b0, make_addr(0, 4, 1), '0, '0);
        run_access(1'b0, make_addr(2, 4, 1), '0, '0);
        run_access(1'b0, make_addr(0, 4, 1), '0, '0);
        run_access(1'b0, make_addr(1, 4, 1), '0, '0);
        end_test();

        start_test("random_mix");
        for (int i = 0; i < mix_ops; i++) begin
            tag_val  = $unsigned($random(seed)) % 4;
            set_idx  = $unsigned($random(seed)) % 3;
            word_idx = $unsigned($random(seed)) % line_words;
            data     = $random(seed);
            be       = $random(seed);
            run_access($random(seed) & 1, make_addr(tag_val, set_idx, word_idx), data, be);
        end
        end_test();

        $display("Totals: %0d tests, %0d checks, %0d errors", num_tests, total_checks, total_errors);
        if (total_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

//--- tests/pmem_model.sv
// Line-wide memory model; only line_bits address bits select a line, so higher addresses alias.
`timescale 1ns/1ps
`default_nettype none

module pmem_model
    import cache_pkg::*;
#(
    parameter int latency   = 5,
    parameter int line_bits = 6
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          pmem_read,
    input  wire          pmem_write,
    input  wire  addr_t  pmem_address,
    input  wire  line_t  pmem_wdata,
    output line_t        pmem_rdata,
    output logic         pmem_resp
);

    localparam int num_lines = 1 << line_bits;

    line_t                lines [num_lines];
    logic                 busy;
    int                   count;
    integer               seed;
    logic [line_bits-1:0] line_idx;

    assign line_idx = pmem_address[offset_w +: line_bits];

    // Random contents, so that a wrong line or word stands out.
    initial begin
        seed       = 32'ha614_5a64;
        pmem_rdata = '0;
        pmem_resp  = 1'b0;
        for (int i = 0; i < num_lines; i++) begin
            for (int w = 0; w < line_words; w++)
                lines[i][w*word_w +: word_w] = $random(seed);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            count     <= 0;
            pmem_resp <= 1'b0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0; // The request is sampled again only after the pulse.
        end else if (!busy) begin
            if (pmem_read || pmem_write) begin
                busy  <= 1'b1;
                count <= 1;
            end
        end else if (count < latency) begin
            count <= count + 1;
        end else begin
            busy      <= 1'b0;
            pmem_resp <= 1'b1;
            if (pmem_write)
                lines[line_idx] <= pmem_wdata;
            else
                pmem_rdata <= lines[line_idx];
        end
    end

endmodule : pmem_model

`default_nettype wire

//--- tests/clock_gen.sv
// Free-running testbench clock; reset is active high and released on a rising edge after reset_cycles.
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : clock_gen

`default_nettype wire

//--- src/cache_top.sv
// Cache top level; the processor holds each request until mem_resp and memory answers with a pulse.
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int set_bits = 3
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              mem_read,
    input  wire              mem_write,
    input  wire  addr_t      mem_address,
    input  wire  word_t      mem_wdata,
    input  wire  [be_w-1:0]  mem_byte_enable,
    input  wire  line_t      pmem_rdata,
    input  wire              pmem_resp,
    output word_t            mem_rdata,
    output logic             mem_resp,
    output logic             stall,
    output logic             pmem_read,
    output logic             pmem_write,
    output addr_t            pmem_address,
    output line_t            pmem_wdata
);

    logic hit;
    logic dirty;
    logic load;
    logic access_sel;
    logic load_lru;
    logic address_sel;

    cache_control u_control (
        .clk         (clk),
        .rst         (rst),
        .pmem_resp   (pmem_resp),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .dirty       (dirty),
        .hit         (hit),
        .load        (load),
        .access_sel  (access_sel),
        .load_lru    (load_lru),
        .pmem_read   (pmem_read),
        .pmem_write  (pmem_write),
        .address_sel (address_sel),
        .mem_resp    (mem_resp),
        .stall       (stall)
    );

    cache_datapath #(
        .set_bits (set_bits)
    ) u_datapath (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .pmem_rdata      (pmem_rdata),
        .load            (load),
        .access_sel      (access_sel),
        .load_lru        (load_lru),
        .address_sel     (address_sel),
        .hit             (hit),
        .dirty           (dirty),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata)
    );

endmodule : cache_top

`default_nettype wire

//--- cache/cache_control.sv
// Cache controller FSM; a miss is answered only after the refill, when the request hits in IDLE.
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  wire  clk,
    input  wire  rst,
    input  wire  pmem_resp,
    input  wire  mem_read,
    input  wire  mem_write,
    input  wire  dirty,
    input  wire  hit,
    output logic load,
    output logic access_sel,
    output logic load_lru,
    output logic pmem_read,
    output logic pmem_write,
    output logic address_sel,
    output logic mem_resp,
    output logic stall
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        MISS,
        BUFFER
    } cache_state_e;

    cache_state_e state;
    cache_state_e next_state;
    logic         request;

    assign request = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        load        = 1'b0;
        access_sel  = 1'b0;
        load_lru    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        address_sel = 1'b0;
        mem_resp    = 1'b0;
        stall       = 1'b1;

        unique case (state)
            IDLE: begin
                stall = !hit;
                if (request && hit) begin
                    load_lru = 1'b1;
                    mem_resp = 1'b1;
                    load     = mem_write; // Write hits merge bytes and mark the line dirty.
                end
            end
            WRITE_BACK: begin
                address_sel = 1'b1; // Victim line address.
                pmem_write  = 1'b1;
            end
            MISS: begin
                pmem_read  = 1'b1;
                access_sel = 1'b1;
                // The refill line is only captured on the response cycle.
                load       = pmem_resp;
            end
            BUFFER: begin
                // Nothing to drive here, the line was captured in MISS.
            end
            default: begin
                stall = 1'b1;
            end
        endcase
    end

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (request && !hit)
                    next_state = dirty ? WRITE_BACK : MISS;
            end
            WRITE_BACK: begin
                if (pmem_resp)
                    next_state = MISS;
            end
            MISS: begin
                if (pmem_resp)
                    next_state = BUFFER;
            end
            BUFFER: begin
                if (!pmem_resp)
                    next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule : cache_control

`default_nettype wire

//--- cache/cache_datapath.sv
// Two-way datapath; the LRU bit of a set names the victim way, and memory addresses are line aligned.
`timescale 1ns/1ps
`default_nettype none

module cache_datapath
    import cache_pkg::*;
#(
    parameter int set_bits = 3
) (
    input  wire              clk,
    input  wire              rst,
    input  wire  addr_t      mem_address,
    input  wire  word_t      mem_wdata,
    input  wire  [be_w-1:0]  mem_byte_enable,
    input  wire  line_t      pmem_rdata,
    input  wire              load,
    input  wire              access_sel,
    input  wire              load_lru,
    input  wire              address_sel,
    output logic             hit,
    output logic             dirty,
    output word_t            mem_rdata,
    output addr_t            pmem_address,
    output line_t            pmem_wdata
);

    localparam int tag_w      = addr_w - set_bits - offset_w;
    localparam int num_sets   = 1 << set_bits;
    localparam int byte_bits  = $clog2(be_w);
    localparam int word_idx_w = offset_w - byte_bits;

    logic [tag_w-1:0]      req_tag;
    logic [set_bits-1:0]   set_index;
    logic [word_idx_w-1:0] word_idx;
    logic [tag_w-1:0]      way_tag [2];
    line_t                 way_line [2];
    logic [1:0]            way_valid;
    logic [1:0]            way_dirty;
    logic [1:0]            way_hit;
    logic [num_sets-1:0]   lru_bits;
    logic                  victim;
    logic                  sel_way;
    line_t                 merged_line;
    line_t                 line_in;

    assign req_tag   = mem_address[addr_w-1 -: tag_w];
    assign set_index = mem_address[offset_w +: set_bits];
    assign word_idx  = mem_address[byte_bits +: word_idx_w];

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way #(
            .set_bits (set_bits)
        ) u_way (
            .clk         (clk),
            .rst         (rst),
            .set_index   (set_index),
            .load_line   (load && (sel_way == w)),
            .line_in     (line_in),
            .tag_in      (req_tag),
            .set_dirty   (load && !access_sel && (sel_way == w)),
            .clear_dirty (load && access_sel && (sel_way == w)),
            .tag_out     (way_tag[w]),
            .valid_out   (way_valid[w]),
            .dirty_out   (way_dirty[w]),
            .line_out    (way_line[w])
        );
        assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
    end

    assign hit     = |way_hit;
    assign victim  = lru_bits[set_index];
    assign sel_way = hit ? way_hit[1] : victim; // Hit way if any, else the victim.
    assign dirty   = way_dirty[victim];

    // The LRU bit is turned toward the way that was not just used.
    always_ff @(posedge clk) begin
        if (rst)
            lru_bits <= '0;
        else if (load_lru)
            lru_bits[set_index] <= ~sel_way;
    end

    // Enabled processor bytes replace the addressed word of the selected line.
    always_comb begin
        merged_line = way_line[sel_way];
        for (int b = 0; b < be_w; b++) begin
            if (mem_byte_enable[b])
                merged_line[word_idx*word_w + b*8 +: 8] = mem_wdata[b*8 +: 8];
        end
    end

    assign line_in   = access_sel ? pmem_rdata : merged_line;
    assign mem_rdata = way_line[sel_way][word_idx*word_w +: word_w];

    // A write-back targets the victim's own line, a fill targets the request line.
    assign pmem_address = address_sel ? {way_tag[victim], set_index, {offset_w{1'b0}}}
                                      : {req_tag, set_index, {offset_w{1'b0}}};
    assign pmem_wdata   = way_line[victim];

endmodule : cache_datapath

`default_nettype wire

//--- cache/cache_way.sv
// One cache way; reads are combinational by set index, and tag and data contents are unknown until loaded.
`timescale 1ns/1ps
`default_nettype none

module cache_way
    import cache_pkg::*;
#(
    parameter int set_bits = 3
) (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire  [set_bits-1:0]                    set_index,
    input  wire                                    load_line,
    input  wire  line_t                            line_in,
    input  wire  [addr_w-set_bits-offset_w-1:0]    tag_in,
    input  wire                                    set_dirty,
    input  wire                                    clear_dirty,
    output logic [addr_w-set_bits-offset_w-1:0]    tag_out,
    output logic                                   valid_out,
    output logic                                   dirty_out,
    output line_t                                  line_out
);

    localparam int tag_w    = addr_w - set_bits - offset_w;
    localparam int num_sets = 1 << set_bits;

    logic [tag_w-1:0]    tag_mem  [num_sets];
    line_t               data_mem [num_sets];
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;

    // Tag and data are written together whenever the way is loaded.
    always_ff @(posedge clk) begin
        if (load_line) begin
            tag_mem[set_index]  <= tag_in;
            data_mem[set_index] <= line_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (load_line)
                valid_bits[set_index] <= 1'b1;
            // A processor write wins over a fill if both were ever asserted.
            if (set_dirty)
                dirty_bits[set_index] <= 1'b1;
            else if (clear_dirty)
                dirty_bits[set_index] <= 1'b0;
        end
    end

    assign tag_out   = tag_mem[set_index];
    assign valid_out = valid_bits[set_index];
    assign dirty_out = dirty_bits[set_index]; // Only meaningful while valid.
    assign line_out  = data_mem[set_index];

endmodule : cache_way

`default_nettype wire

//--- common/cache_pkg.sv
// Shared widths and types; the line is fixed at 8 words of 32 bits and the address is 32 bits.
`default_nettype none

package cache_pkg;

    // Processor side widths.
    localparam int addr_w = 32;
    localparam int word_w = 32;
    localparam int be_w   = word_w / 8; // One enable per byte lane.

    // A line is what one memory transaction moves.
    localparam int line_words = 8;
    localparam int line_w     = line_words * word_w;

    // Byte offset within a line, five bits for a 32 byte line.
    localparam int offset_w = $clog2(line_w / 8);

    // A byte address as seen on both ports.
    typedef logic [addr_w-1:0] addr_t;

    // One processor data word.
    typedef logic [word_w-1:0] word_t;

    // One full cache line, word 0 in the low bits.
    typedef logic [line_w-1:0] line_t;

endpackage : cache_pkg

`default_nettype wire
